// ==== Makefile ====
# Verilator build and run of the vector IIR filter testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_viir -f list.f -Mdir obj_dir -o viir_sim

# The log must hold the pass line, otherwise make fails
run: compile
	./obj_dir/viir_sim | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/viir_pkg.sv ====
//------------------------------
// Shared constants and the sample type for the vector IIR filter.
// Every RTL module imports this package with a wildcard import.
// It holds the register map, the datapath widths and the complex
// sample union used on the streams, in the delay memory and in the MAC.
//------------------------------

package viir_pkg;

  //------------------------------
  // Vector length limits
  //------------------------------

  // Largest vector length and the size of the delay memory
  localparam int MAX_DELAY = 255;

  // Smallest vector length
  // Equal to the pipeline depth so y[n-D] is written before it is read
  localparam int MIN_DELAY = 2;

  // Width of the delay field and of the delay pointer
  localparam int DELAY_W = 8;

  //------------------------------
  // Datapath widths
  //------------------------------

  // One complex sample with I in the upper half and Q in the lower half
  localparam int SAMPLE_W = 32;

  // One real or imaginary part
  localparam int PART_W = SAMPLE_W / 2;

  // Alpha and beta are signed Q1.15
  localparam int TAP_W = 16;

  // Shift that brings a Q1.15 product back to sample scale
  localparam int FRAC_BITS = 15;

  // Sum of two full products with one guard bit for the addition
  localparam int ACC_W = TAP_W + PART_W + 1;

  //------------------------------
  // APB register map
  //------------------------------

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] REG_DELAY = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_ALPHA = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_BETA  = 8'h08;

  // Bit position of the read-only MAX_DELAY field in the DELAY register
  localparam int MAX_DELAY_POS = 16;

  //------------------------------
  // Sample word
  //------------------------------

  // Streams and memory see the raw word and the MAC sees the two parts
  typedef union packed {
    logic [SAMPLE_W-1:0] raw;
    struct packed {
      logic signed [PART_W-1:0] i;
      logic signed [PART_W-1:0] q;
    } iq;
  } viir_sample_t;

endpackage

// ==== iir/viir_core.sv ====
//------------------------------
// Stream pipeline of the vector IIR filter.
// Stage one holds the accepted sample while the delay line fetches
// y[n-D]. Stage two holds the MAC result, which is the output word.
// Back-pressure freezes both stages; flush drops what is in flight.
//------------------------------

`timescale 1ns/1ps

module viir_core
  import viir_pkg::*;
(
  input  logic               ce_clk,
  input  logic               ce_rst,
  input  logic               flush,
  input  logic [DELAY_W-1:0] delay_len,
  input  logic [TAP_W-1:0]   alpha,
  input  logic [TAP_W-1:0]   beta,
  // Input stream
  input  viir_sample_t       s_tdata,
  input  logic               s_tlast,
  input  logic               s_tvalid,
  output logic               s_tready,
  // Output stream
  output viir_sample_t       m_tdata,
  output logic               m_tlast,
  output logic               m_tvalid,
  input  logic               m_tready
);

  logic         stall;
  logic         advance;
  logic         s1_valid;
  logic         s1_last;
  viir_sample_t s1_data;
  logic         s2_valid;
  viir_sample_t y_del;
  viir_sample_t mac_y;

  // Output word waiting on a busy sink holds the whole pipeline
  assign stall    = s2_valid & ~m_tready;
  // No sample enters while history is being cleared
  assign s_tready = ~stall & ~flush;
  assign advance  = s_tvalid & s_tready;
  assign m_tvalid = s2_valid;

  //------------------------------
  // Stage one
  //------------------------------

  always_ff @(posedge ce_clk) begin
    if (ce_rst || flush) begin
      s1_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= advance;
    end
  end

  // Held between accepts so the MAC keeps this sample's result
  always_ff @(posedge ce_clk) begin
    if (advance) begin
      s1_data <= s_tdata;
      s1_last <= s_tlast;
    end
  end

  //------------------------------
  // Stage two
  //------------------------------

  always_ff @(posedge ce_clk) begin
    if (ce_rst || flush) begin
      s2_valid <= 1'b0;
    end else if (!stall) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!stall && s1_valid) begin
      m_tdata <= mac_y;
      m_tlast <= s1_last;
    end
  end

  //------------------------------
  // History and arithmetic
  //------------------------------

  viir_delay_line delay_line0 (
    .ce_clk    (ce_clk),
    .ce_rst    (ce_rst),
    .flush     (flush),
    .advance   (advance),
    .delay_len (delay_len),
    .wr_data   (mac_y),
    .rd_data   (y_del)
  );

  viir_mac mac0 (
    .x     (s1_data),
    .y_del (y_del),
    .alpha (alpha),
    .beta  (beta),
    .y     (mac_y)
  );

  // Sink sees the same word until it takes it
  a_out_stable: assert property (
    @(posedge ce_clk) disable iff (ce_rst)
    (m_tvalid && !m_tready) |=> ($stable(m_tdata) && $stable(m_tlast))
  );

endmodule

// ==== iir/viir_delay_line.sv ====
//------------------------------
// Circular history memory of the vector IIR filter.
// Returns y[n-D] one cycle after each advance and stores the result of
// the previous sample in the slot that was read for it.
// Reads give zero until the pointer first wraps after reset or flush.
//------------------------------

`timescale 1ns/1ps

module viir_delay_line
  import viir_pkg::*;
(
  input  logic               ce_clk,
  input  logic               ce_rst,
  input  logic               flush,
  input  logic               advance,
  input  logic [DELAY_W-1:0] delay_len,
  input  viir_sample_t       wr_data,
  output viir_sample_t       rd_data
);

  // History words in their raw view
  logic [SAMPLE_W-1:0] mem [MAX_DELAY+1];

  logic [DELAY_W-1:0] ptr;
  logic [DELAY_W-1:0] wr_ptr;
  logic               wrap;
  logic               filled;
  logic               wr_pend;

  // Pointer goes back to zero after the last slot of the vector
  assign wrap = (ptr >= delay_len - 1'b1);

  //------------------------------
  // Pointer and history state
  //------------------------------

  always_ff @(posedge ce_clk) begin
    if (ce_rst || flush) begin
      ptr     <= '0;
      wr_ptr  <= '0;
      filled  <= 1'b0;
      wr_pend <= 1'b0;
    end else if (advance) begin
      // Slot just read gets this sample's result on the next advance
      wr_ptr  <= ptr;
      wr_pend <= 1'b1;
      ptr     <= wrap ? '0 : ptr + 1'b1;
      if (wrap) begin
        filled <= 1'b1;
      end
    end
  end

  //------------------------------
  // Memory access
  //------------------------------

  // The MAC output still holds the previous sample's result here,
  // since its inputs only change on an advance
  always_ff @(posedge ce_clk) begin
    if (advance) begin
      rd_data.raw <= filled ? mem[ptr] : '0;
      if (wr_pend) begin
        mem[wr_ptr] <= wr_data.raw;
      end
    end
  end

  // Core blocks its input during flush, so history is never read mid-clear
  a_no_advance_on_flush: assert property (
    @(posedge ce_clk) disable iff (ce_rst) !(advance && flush)
  );

endmodule

// ==== iir/viir_mac.sv ====
//------------------------------
// Complex scale and accumulate of the vector IIR filter.
// Forms beta*x + alpha*y_del on I and Q separately at full precision,
// shifts back to sample scale and saturates to 16 bits.
// Purely combinational, it sits between the two pipeline registers.
//------------------------------

`timescale 1ns/1ps

module viir_mac
  import viir_pkg::*;
(
  input  viir_sample_t             x,
  input  viir_sample_t             y_del,
  input  logic signed [TAP_W-1:0]  alpha,
  input  logic signed [TAP_W-1:0]  beta,
  output viir_sample_t             y
);

  //------------------------------
  // One part of the complex sample
  //------------------------------

  function automatic logic signed [PART_W-1:0] scale_part(
    input logic signed [PART_W-1:0] xp,
    input logic signed [PART_W-1:0] yp,
    input logic signed [TAP_W-1:0]  a,
    input logic signed [TAP_W-1:0]  b
  );
    logic signed [ACC_W-1:0]  sum;
    logic signed [ACC_W-1:0]  shifted;
    logic                     fits;
    logic signed [PART_W-1:0] result;
    // Operands widen to the sum width with sign, so nothing is lost
    sum     = b * xp + a * yp;
    shifted = sum >>> FRAC_BITS;
    // Fits when every bit above the part's sign bit copies the sign
    fits    = (&shifted[ACC_W-1:PART_W-1]) | ~(|shifted[ACC_W-1:PART_W-1]);
    if (fits) begin
      result = shifted[PART_W-1:0];
    end else if (shifted[ACC_W-1]) begin
      // Most negative part value
      result = {1'b1, {(PART_W-1){1'b0}}};
    end else begin
      // Most positive part value
      result = {1'b0, {(PART_W-1){1'b1}}};
    end
    return result;
  endfunction

  //------------------------------
  // I and Q lanes
  //------------------------------

  always_comb begin
    y.iq.i = scale_part(x.iq.i, y_del.iq.i, alpha, beta);
    y.iq.q = scale_part(x.iq.q, y_del.iq.q, alpha, beta);
  end

endmodule

// ==== list.f ====
common/viir_pkg.sv
logic/viir_regs.sv
iir/viir_delay_line.sv
iir/viir_mac.sv
iir/viir_core.sv
logic/viir_top.sv
tests/viir_clkgen.sv
tests/tb_viir.sv

// ==== logic/viir_regs.sv ====
//------------------------------
// APB register slave of the vector IIR filter.
// Holds the vector length, alpha and beta, with no wait states.
// Any accepted write to a known register raises flush for one cycle,
// which clears the filter history and the samples in flight.
// Unknown addresses answer with pslverr and change nothing.
//------------------------------

`timescale 1ns/1ps

module viir_regs
  import viir_pkg::*;
(
  input  logic                  ce_clk,
  input  logic                  ce_rst,
  // APB slave
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Filter settings
  output logic [DELAY_W-1:0]    delay_len,
  output logic [TAP_W-1:0]      alpha,
  output logic [TAP_W-1:0]      beta,
  output logic                  flush
);

  logic               access;
  logic               addr_ok;
  logic               wr_ok;
  logic [DELAY_W-1:0] wr_delay;

  // Access phase of any transfer
  assign access = psel & penable;

  // No wait states
  assign pready  = access;
  assign pslverr = access & ~addr_ok;
  assign wr_ok   = access & pwrite & addr_ok;

  // Lengths below the pipeline depth would read history not yet written
  assign wr_delay = (pwdata[DELAY_W-1:0] < DELAY_W'(MIN_DELAY)) ?
                    DELAY_W'(MIN_DELAY) : pwdata[DELAY_W-1:0];

  //------------------------------
  // Address decode and readback
  //------------------------------

  always_comb begin
    prdata  = '0;
    addr_ok = 1'b1;
    case (paddr)
      REG_DELAY: begin
        prdata[DELAY_W-1:0]             = delay_len;
        prdata[MAX_DELAY_POS +: DELAY_W] = DELAY_W'(MAX_DELAY);
      end
      // Taps read back sign extended
      REG_ALPHA: prdata = {{(APB_DATA_W-TAP_W){alpha[TAP_W-1]}}, alpha};
      REG_BETA:  prdata = {{(APB_DATA_W-TAP_W){beta[TAP_W-1]}}, beta};
      default:   addr_ok = 1'b0;
    endcase
  end

  //------------------------------
  // Register writes
  //------------------------------

  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      delay_len <= DELAY_W'(MIN_DELAY);
      alpha     <= '0;
      beta      <= '0;
      flush     <= 1'b0;
    end else begin
      // Write lands at the end of the access phase, flush follows a cycle later
      flush <= wr_ok;
      if (wr_ok) begin
        case (paddr)
          REG_DELAY: delay_len <= wr_delay;
          REG_ALPHA: alpha     <= pwdata[TAP_W-1:0];
          REG_BETA:  beta      <= pwdata[TAP_W-1:0];
          default:   ;
        endcase
      end
    end
  end

  // An APB transfer needs a setup phase, so two flushes never touch
  a_flush_single: assert property (
    @(posedge ce_clk) disable iff (ce_rst) flush |=> !flush
  );

endmodule

// ==== logic/viir_top.sv ====
//------------------------------
// Top level of the vector IIR filter.
// APB sets delay, alpha and beta; complex samples stream in and out
// with a valid/ready handshake and a last flag carried through.
//------------------------------

`timescale 1ns/1ps

module viir_top
  import viir_pkg::*;
(
  input  logic                  ce_clk,
  input  logic                  ce_rst,
  // APB slave
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Input stream
  input  logic [SAMPLE_W-1:0]   s_tdata,
  input  logic                  s_tlast,
  input  logic                  s_tvalid,
  output logic                  s_tready,
  // Output stream
  output logic [SAMPLE_W-1:0]   m_tdata,
  output logic                  m_tlast,
  output logic                  m_tvalid,
  input  logic                  m_tready
);

  logic [DELAY_W-1:0] delay_len;
  logic [TAP_W-1:0]   alpha;
  logic [TAP_W-1:0]   beta;
  logic               flush;

  viir_regs regs0 (
    .ce_clk    (ce_clk),
    .ce_rst    (ce_rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .delay_len (delay_len),
    .alpha     (alpha),
    .beta      (beta),
    .flush     (flush)
  );

  // Raw stream words map onto the sample union one to one
  viir_core core0 (
    .ce_clk    (ce_clk),
    .ce_rst    (ce_rst),
    .flush     (flush),
    .delay_len (delay_len),
    .alpha     (alpha),
    .beta      (beta),
    .s_tdata   (s_tdata),
    .s_tlast   (s_tlast),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .m_tdata   (m_tdata),
    .m_tlast   (m_tlast),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready)
  );

endmodule

// ==== tests/tb_viir.sv ====
//------------------------------
// Testbench for the vector IIR filter top level
// Drives APB and the input stream on falling edges, predicts every
// output word with its own model of the filter, and checks the
// APB answers and the output stream with concurrent assertions
//------------------------------

`timescale 1ns/1ps

module tb_viir
  import viir_pkg::*;
();

  localparam int TIMEOUT   = 2000;
  localparam int EXP_DEPTH = 1024;

  logic        ce_clk;
  logic        ce_rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] s_tdata;
  logic        s_tlast;
  logic        s_tvalid;
  logic        s_tready;
  logic [31:0] m_tdata;
  logic        m_tlast;
  logic        m_tvalid;
  logic        m_tready = 1'b1;

  // Checker state
  string       test_name = "reset";
  int          errors = 0;
  int          test_base = 0;
  int          tests_run = 0;
  // Sink ready and sample words draw from their own seeds
  integer      seed = 67476;
  integer      data_seed = 67476;
  logic        random_ready = 1'b0;
  logic        rd_check = 1'b0;
  logic [31:0] exp_rdata = '0;
  logic        exp_err = 1'b0;

  // Model state
  // An empty history stands for a flushed filter
  logic [31:0] hist_q [$];
  int          cur_delay = MIN_DELAY;
  logic [15:0] cur_alpha = '0;
  logic [15:0] cur_beta = '0;

  // Predicted {tlast, data} words in output order
  logic [32:0] exp_mem [EXP_DEPTH];
  int          exp_wr = 0;
  int          exp_rd = 0;
  int          in_count = 0;
  logic [32:0] exp_head;
  logic [32:0] out_word;

  assign exp_head = exp_mem[exp_rd % EXP_DEPTH];
  assign out_word = {m_tlast, m_tdata};

  viir_clkgen clkgen0 (
    .ce_clk (ce_clk),
    .ce_rst (ce_rst)
  );

  viir_top dut0 (
    .ce_clk   (ce_clk),
    .ce_rst   (ce_rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .s_tdata  (s_tdata),
    .s_tlast  (s_tlast),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tlast  (m_tlast),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
  );

  //------------------------------
  // Reporting
  //------------------------------

  task automatic report_mismatch(input string what, input logic [32:0] expected,
                                 input logic [32:0] actual);
    errors++;
    $display("** Error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Test %s: %s", test_name, msg);
  endtask

  task automatic fail_timeout(input string what);
    errors++;
    $display("Test %s: timed out waiting for %s", test_name, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  //------------------------------
  // Reference model
  //------------------------------

  // One part gets a full precision sum, an arithmetic shift and a clamp to 16 bits
  function automatic logic [15:0] model_part(input logic signed [15:0] xp,
                                             input logic signed [15:0] yp,
                                             input logic signed [15:0] a,
                                             input logic signed [15:0] b);
    longint sum;
    longint sh;
    sum = longint'(b) * longint'(xp) + longint'(a) * longint'(yp);
    sh  = sum >>> FRAC_BITS;
    if (sh > 32767) begin
      model_part = 16'h7fff;
    end else if (sh < -32768) begin
      model_part = 16'h8000;
    end else begin
      model_part = sh[15:0];
    end
  endfunction

  // y_del is the output D samples back and zero until D outputs exist
  task automatic model_push(input logic [31:0] x, input logic last);
    logic [31:0] yd;
    logic [31:0] y;
    yd = '0;
    if (hist_q.size() >= cur_delay) begin
      yd = hist_q[hist_q.size() - cur_delay];
    end
    y[31:16] = model_part(x[31:16], yd[31:16], cur_alpha, cur_beta);
    y[15:0]  = model_part(x[15:0], yd[15:0], cur_alpha, cur_beta);
    hist_q.push_back(y);
    exp_mem[exp_wr % EXP_DEPTH] = {last, y};
    exp_wr++;
  endtask

  // Writes to the three registers update the model and flush history
  task automatic model_config(input logic [7:0] addr, input logic [31:0] data);
    case (addr)
      REG_DELAY: cur_delay = (data[7:0] < MIN_DELAY) ? MIN_DELAY : int'(data[7:0]);
      REG_ALPHA: cur_alpha = data[15:0];
      REG_BETA:  cur_beta  = data[15:0];
      default:   return;
    endcase
    hist_q.delete();
  endtask

  function automatic logic [31:0] delay_word(input logic [7:0] d);
    delay_word = {8'h00, 8'(MAX_DELAY), 8'h00, d};
  endfunction

  //------------------------------
  // APB master
  //------------------------------

  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic check,
                            input logic [31:0] rdata_exp, input logic err_exp);
    int n;
    // Setup phase
    psel      = 1'b1;
    penable   = 1'b0;
    pwrite    = write;
    paddr     = addr;
    pwdata    = wdata;
    rd_check  = check;
    exp_rdata = rdata_exp;
    exp_err   = err_exp;
    @(negedge ce_clk);
    // Access phase ends on the edge where pready is seen
    penable = 1'b1;
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge ce_clk);
      if (pready) begin
        break;
      end
    end
    if (n == TIMEOUT) begin
      fail_timeout("APB pready");
    end
    @(negedge ce_clk);
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    rd_check = 1'b0;
    if (write) begin
      model_config(addr, wdata);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic err_exp);
    apb_access(1'b1, addr, data, 1'b0, '0, err_exp);
  endtask

  task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] expected,
                                input logic err_exp);
    apb_access(1'b0, addr, '0, ~err_exp, expected, err_exp);
  endtask

  //------------------------------
  // Stream driver and sink
  //------------------------------

  task automatic send_sample(input logic [31:0] data, input logic last);
    int n;
    int target;
    target   = in_count + 1;
    s_tvalid = 1'b1;
    s_tdata  = data;
    s_tlast  = last;
    model_push(data, last);
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge ce_clk);
      if (in_count == target) begin
        break;
      end
    end
    if (n == TIMEOUT) begin
      fail_timeout("input handshake");
    end
  endtask

  task automatic send_vector(input int len);
    int          k;
    logic [31:0] word;
    for (k = 0; k < len; k++) begin
      word = $random(data_seed);
      send_sample(word, k == len - 1);
    end
    s_tvalid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      if (exp_rd == exp_wr) begin
        break;
      end
      @(negedge ce_clk);
    end
    if (n == TIMEOUT) begin
      fail_timeout("output words");
    end
  endtask

  // Sink ready is either always high or a coin flip per cycle
  always @(negedge ce_clk) begin
    m_tready = random_ready ? 1'($random(seed) & 1) : 1'b1;
  end

  // Handshake counters
  always @(posedge ce_clk) begin
    if (s_tvalid && s_tready) begin
      in_count <= in_count + 1;
    end
    if (m_tvalid && m_tready) begin
      exp_rd <= exp_rd + 1;
    end
  end

  //------------------------------
  // Checks
  //------------------------------

  a_apb_err: assert property (
    @(posedge ce_clk) disable iff (ce_rst) (psel && penable) |-> (pslverr == exp_err)
  ) else report_mismatch("pslverr", 33'($sampled(exp_err)), 33'($sampled(pslverr)));

  a_apb_rdata: assert property (
    @(posedge ce_clk) disable iff (ce_rst)
    (psel && penable && !pwrite && rd_check) |-> (prdata == exp_rdata)
  ) else report_mismatch("prdata", 33'($sampled(exp_rdata)), 33'($sampled(prdata)));

  a_no_extra: assert property (
    @(posedge ce_clk) disable iff (ce_rst) (m_tvalid && m_tready) |-> (exp_rd != exp_wr)
  ) else report_failure("output word with no sample pending");

  // Compares {tlast, data} of every accepted output word
  a_out_word: assert property (
    @(posedge ce_clk) disable iff (ce_rst)
    (m_tvalid && m_tready && exp_rd != exp_wr) |-> (out_word == exp_head)
  ) else report_mismatch("output word", $sampled(exp_head), $sampled(out_word));

  //------------------------------
  // Test sequence
  //------------------------------

  task automatic start_test(input string name);
    test_name = name;
    test_base = errors;
    tests_run++;
  endtask

  task automatic end_test();
    wait_drain();
    $display("Test %s finished with %0d error(s)", test_name, errors - test_base);
  endtask

  initial begin
    int n;
    int k;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    s_tdata  = '0;
    s_tlast  = 1'b0;
    s_tvalid = 1'b0;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge ce_clk);
      if (!ce_rst) begin
        break;
      end
    end
    if (n == TIMEOUT) begin
      fail_timeout("reset release");
    end

    // A delay of 1 reads back as the minimum
    start_test("readback");
    apb_write(REG_DELAY, 32'd1, 1'b0);
    apb_read_check(REG_DELAY, delay_word(8'(MIN_DELAY)), 1'b0);
    apb_write(REG_DELAY, 32'd9, 1'b0);
    apb_read_check(REG_DELAY, delay_word(8'd9), 1'b0);
    apb_write(REG_ALPHA, 32'h0000_c000, 1'b0);
    apb_read_check(REG_ALPHA, 32'hffff_c000, 1'b0);
    apb_write(REG_BETA, 32'h0000_1234, 1'b0);
    apb_read_check(REG_BETA, 32'h0000_1234, 1'b0);
    end_test();

    start_test("bad_address");
    apb_write(8'h0c, 32'h0000_0005, 1'b1);
    apb_read_check(8'h0c, '0, 1'b1);
    apb_read_check(REG_DELAY, delay_word(8'd9), 1'b0);
    apb_read_check(REG_ALPHA, 32'hffff_c000, 1'b0);
    apb_read_check(REG_BETA, 32'h0000_1234, 1'b0);
    end_test();

    // Beta of one half and no feedback halves each part
    start_test("scaling");
    apb_write(REG_DELAY, 32'd4, 1'b0);
    apb_write(REG_ALPHA, 32'h0000_0000, 1'b0);
    apb_write(REG_BETA, 32'h0000_4000, 1'b0);
    send_vector(4);
    send_vector(4);
    end_test();

    start_test("recursion");
    apb_write(REG_ALPHA, 32'h0000_6000, 1'b0);
    apb_write(REG_BETA, 32'h0000_2000, 1'b0);
    for (k = 0; k < 5; k++) begin
      send_vector(4);
    end
    end_test();

    // Full scale taps drive the second vector into both clamps
    start_test("saturation");
    apb_write(REG_DELAY, 32'd2, 1'b0);
    apb_write(REG_ALPHA, 32'h0000_7fff, 1'b0);
    apb_write(REG_BETA, 32'h0000_7fff, 1'b0);
    for (k = 0; k < 3; k++) begin
      send_sample(32'h7fff_8000, 1'b0);
      send_sample(32'h8000_7fff, 1'b1);
    end
    s_tvalid = 1'b0;
    end_test();

    // Random stalls first and then a tap write that flushes the history
    start_test("backpressure");
    apb_write(REG_DELAY, 32'd5, 1'b0);
    apb_write(REG_ALPHA, 32'h0000_7000, 1'b0);
    apb_write(REG_BETA, 32'h0000_3000, 1'b0);
    random_ready = 1'b1;
    for (k = 0; k < 6; k++) begin
      send_vector(5);
    end
    wait_drain();
    apb_write(REG_ALPHA, 32'h0000_5000, 1'b0);
    send_vector(5);
    end_test();
    random_ready = 1'b0;

    $display("Tests run %0d, failed checks %0d", tests_run, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tests/viir_clkgen.sv ====
//------------------------------
// Testbench clock and reset source
// 40 ns clock, reset held high over the first two rising edges
// and released on a falling edge
//------------------------------

`timescale 1ns/1ps

module viir_clkgen (
  output logic ce_clk,
  output logic ce_rst
);

  initial begin
    ce_clk = 1'b0;
    forever #20 ce_clk = ~ce_clk;
  end

  // Release lands on the falling edge, like every other input
  initial begin
    ce_rst = 1'b1;
    repeat (2) @(posedge ce_clk);
    @(negedge ce_clk);
    ce_rst = 1'b0;
  end

endmodule
